/* logic/fpslice_pkg.sv */
package fpslice_pkg;

  // --------------------------------------------------------------------------
  // Formats and operations
  // --------------------------------------------------------------------------
  typedef enum logic [0:0] {
    FMT_FP32,
    FMT_FP16
  } fp_fmt_e;

  typedef enum logic [2:0] {
    OP_MIN,
    OP_MAX,
    OP_SGNJ,
    OP_SGNJN,
    OP_SGNJX
  } nc_op_e;

  localparam int unsigned MIN_LANE_WIDTH = 16; // FP16 is the narrowest element

  typedef logic [31:0] lane_word_t; // One element at the widest lane format
  typedef logic [7:0]  tag_t;       // Opaque, travels with the operation

  localparam lane_word_t CANON_NAN32 = 32'h7fc0_0000;
  localparam logic [15:0] CANON_NAN16 = 16'h7e00;

  // IEEE exception flags, invalid is the only one these ops can raise
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef struct packed {
    fp_fmt_e fmt;
    nc_op_e  op;
  } lane_ctrl_t;

  // Carried alongside the lane data down the pipeline
  typedef struct packed {
    fp_fmt_e fmt;
    logic    vectorial;
    tag_t    tag;
  } slice_aux_t;

  typedef struct packed {
    lane_word_t value;
    status_t    status;
  } lane_res_t;

  // --------------------------------------------------------------------------
  // Lane helpers
  // --------------------------------------------------------------------------
  function automatic int unsigned fp_width(fp_fmt_e fmt);
    return (fmt == FMT_FP32) ? 32 : 16;
  endfunction

  function automatic int unsigned num_lanes(int unsigned width, fp_fmt_e fmt);
    return width / fp_width(fmt); // Elements of this format that fit the vector
  endfunction

endpackage

/* logic/slice_decode.sv */
`timescale 1ns/10ps

module slice_decode import fpslice_pkg::*; #(
  parameter int unsigned Width = 64,
  localparam int unsigned NumLanes = Width / MIN_LANE_WIDTH
) (
  input  logic [1:0][Width-1:0]      operands_i,
  input  nc_op_e                     op_i,
  input  fp_fmt_e                    fmt_i,
  input  logic                       vectorial_op_i,
  input  tag_t                       tag_i,
  output lane_ctrl_t                 ctrl_o,
  output lane_word_t [NumLanes-1:0]  lane_a_o,
  output lane_word_t [NumLanes-1:0]  lane_b_o,
  output slice_aux_t                 aux_o
);

  int unsigned elem_width;

  // --------------------------------------------------------------------------
  // Operation control, shared by every lane
  // --------------------------------------------------------------------------
  assign ctrl_o.fmt = fmt_i;
  assign ctrl_o.op  = op_i;

  // Format and vector flag are needed again when packing the result
  assign aux_o.fmt       = fmt_i;
  assign aux_o.vectorial = vectorial_op_i;
  assign aux_o.tag       = tag_i;

  assign elem_width = fp_width(fmt_i);

  // --------------------------------------------------------------------------
  // Operand slicing
  // --------------------------------------------------------------------------
  // Each lane sees its element in the low bits; whatever sits above it is
  // ignored by the lane for FP16
  always_comb begin : slice_operands
    logic [Width-1:0] shifted_a;
    logic [Width-1:0] shifted_b;
    shifted_a = '0;
    shifted_b = '0;
    for (int unsigned i = 0; i < NumLanes; i++) begin
      shifted_a   = operands_i[0] >> (i * elem_width);
      shifted_b   = operands_i[1] >> (i * elem_width);
      lane_a_o[i] = lane_word_t'(shifted_a);  // Keep the lowest 32 bits
      lane_b_o[i] = lane_word_t'(shifted_b);
    end
  end

endmodule

/* logic/lane_nc_unit.sv */
`timescale 1ns/10ps

module lane_nc_unit import fpslice_pkg::*; #(
  parameter bit SupportsFp32 = 1'b1
) (
  input  lane_ctrl_t ctrl_i,
  input  lane_word_t a_i,
  input  lane_word_t b_i,
  output lane_res_t  res_o
);

  // Format-independent view of one operand
  typedef struct packed {
    logic        sign;
    logic [30:0] mag;     // Exponent and mantissa, zero extended
    logic        is_nan;
    logic        is_snan;
  } elem_t;

  function automatic elem_t classify(lane_word_t x, logic wide);
    elem_t e;
    if (wide) begin
      e.sign    = x[31];
      e.mag     = x[30:0];
      e.is_nan  = (&x[30:23]) & (|x[22:0]);
      e.is_snan = e.is_nan & ~x[22]; // Quiet bit clear
    end else begin
      e.sign    = x[15];
      e.mag     = {16'h0, x[14:0]};
      e.is_nan  = (&x[14:10]) & (|x[9:0]);
      e.is_snan = e.is_nan & ~x[9];
    end
    return e;
  endfunction

  logic       is_fp32;
  elem_t      elem_a, elem_b;
  logic       a_lt_b;
  logic       inj_sign;
  lane_word_t a_fmt, b_fmt;
  lane_word_t nan_fmt;
  lane_word_t sgnj_res;

  // Narrow lanes never see FP32
  assign is_fp32 = SupportsFp32 && (ctrl_i.fmt == FMT_FP32);

  assign elem_a = classify(a_i, is_fp32);
  assign elem_b = classify(b_i, is_fp32);

  // Operands and canonical NaN as they leave the lane, FP16 upper half zero
  assign a_fmt   = is_fp32 ? a_i : {16'h0, a_i[15:0]};
  assign b_fmt   = is_fp32 ? b_i : {16'h0, b_i[15:0]};
  assign nan_fmt = is_fp32 ? CANON_NAN32 : {16'h0, CANON_NAN16};

  // --------------------------------------------------------------------------
  // Ordering, sign-magnitude compare
  // --------------------------------------------------------------------------
  always_comb begin : compare
    if (elem_a.sign != elem_b.sign) begin
      a_lt_b = elem_a.sign;                // Also orders -0 below +0
    end else if (elem_a.sign) begin
      a_lt_b = elem_a.mag > elem_b.mag;    // Larger magnitude is smaller
    end else begin
      a_lt_b = elem_a.mag < elem_b.mag;
    end
  end

  // --------------------------------------------------------------------------
  // Sign injection
  // --------------------------------------------------------------------------
  always_comb begin : sign_inject
    case (ctrl_i.op)
      OP_SGNJN: inj_sign = ~elem_b.sign;
      OP_SGNJX: inj_sign = elem_a.sign ^ elem_b.sign;
      default:  inj_sign = elem_b.sign;
    endcase
    sgnj_res = is_fp32 ? {inj_sign, a_i[30:0]} : {16'h0, inj_sign, a_i[14:0]};
  end

  // --------------------------------------------------------------------------
  // Result select
  // --------------------------------------------------------------------------
  always_comb begin : result_select
    res_o.status = '0;
    case (ctrl_i.op)
      OP_MIN, OP_MAX: begin
        if (elem_a.is_nan && elem_b.is_nan) begin
          res_o.value = nan_fmt;
        end else if (elem_a.is_nan) begin
          res_o.value = b_fmt;  // NaN loses against a number
        end else if (elem_b.is_nan) begin
          res_o.value = a_fmt;
        end else if ((ctrl_i.op == OP_MIN) == a_lt_b) begin
          res_o.value = a_fmt;
        end else begin
          res_o.value = b_fmt;
        end
        res_o.status.nv = elem_a.is_snan | elem_b.is_snan;
      end
      default: res_o.value = sgnj_res; // Flags stay clear
    endcase
  end

endmodule

/* logic/slice_pipe.sv */
`timescale 1ns/10ps

module slice_pipe import fpslice_pkg::*; #(
  parameter int unsigned Width       = 64,
  parameter int unsigned NumPipeRegs = 1,
  localparam int unsigned NumLanes = Width / MIN_LANE_WIDTH
) (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      flush_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  lane_res_t [NumLanes-1:0]  lanes_i,
  input  slice_aux_t                aux_i,
  input  logic [NumLanes-1:0]       mask_i,
  output logic                      out_valid_o,
  input  logic                      out_ready_i,
  output lane_res_t [NumLanes-1:0]  lanes_o,
  output slice_aux_t                aux_o,
  output logic [NumLanes-1:0]       mask_o,
  output logic                      busy_o
);

  // Index i holds the item after i register stages
  logic                     valid_q     [0:NumPipeRegs];
  logic                     stage_ready [0:NumPipeRegs];
  lane_res_t [NumLanes-1:0] lanes_q     [0:NumPipeRegs];
  slice_aux_t               aux_q       [0:NumPipeRegs];
  logic [NumLanes-1:0]      mask_q      [0:NumPipeRegs];

  assign valid_q[0] = in_valid_i;
  assign lanes_q[0] = lanes_i;
  assign aux_q[0]   = aux_i;
  assign mask_q[0]  = mask_i;

  // --------------------------------------------------------------------------
  // Register stages
  // --------------------------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stages
    // Advance when downstream takes the item or only holds a bubble
    assign stage_ready[i] = stage_ready[i+1] | ~valid_q[i+1];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // Payload only moves with a valid item
    always_ff @(posedge clk_i) begin
      if (stage_ready[i] && valid_q[i]) begin
        lanes_q[i+1] <= lanes_q[i];
        aux_q[i+1]   <= aux_q[i];
        mask_q[i+1]  <= mask_q[i];
      end
    end
  end

  assign stage_ready[NumPipeRegs] = out_ready_i; // Driven from downstream
  assign in_ready_o               = stage_ready[0];

  assign out_valid_o = valid_q[NumPipeRegs];
  assign lanes_o     = lanes_q[NumPipeRegs];
  assign aux_o       = aux_q[NumPipeRegs];
  assign mask_o      = mask_q[NumPipeRegs];

  // Items held in any register stage
  always_comb begin : busy_detect
    busy_o = 1'b0;
    for (int unsigned i = 1; i <= NumPipeRegs; i++) begin
      busy_o |= valid_q[i];
    end
  end

endmodule

/* logic/slice_result.sv */
`timescale 1ns/10ps

module slice_result import fpslice_pkg::*; #(
  parameter int unsigned Width = 64,
  localparam int unsigned NumLanes = Width / MIN_LANE_WIDTH
) (
  input  lane_res_t [NumLanes-1:0] lanes_i,
  input  slice_aux_t               aux_i,
  input  logic [NumLanes-1:0]      mask_i,
  output logic [Width-1:0]         result_o,
  output status_t                  status_o,
  output tag_t                     tag_o
);

  localparam int unsigned NumLanes32 = num_lanes(Width, FMT_FP32);
  localparam int unsigned NumLanes16 = num_lanes(Width, FMT_FP16);

  int unsigned used_lanes;

  // Scalars only occupy lane 0
  assign used_lanes = aux_i.vectorial ? num_lanes(Width, aux_i.fmt) : 1;

  assign tag_o = aux_i.tag;

  // --------------------------------------------------------------------------
  // Result packing
  // --------------------------------------------------------------------------
  always_comb begin : pack_result
    result_o = '1; // Unused upper slots stay NaN-boxed
    if (aux_i.fmt == FMT_FP32) begin
      for (int unsigned i = 0; i < NumLanes32; i++) begin
        if (i < used_lanes) begin
          result_o[i*32 +: 32] = lanes_i[i].value;
        end
      end
    end else begin
      for (int unsigned i = 0; i < NumLanes16; i++) begin
        if (i < used_lanes) begin
          result_o[i*16 +: 16] = lanes_i[i].value[15:0];
        end
      end
    end
  end

  // --------------------------------------------------------------------------
  // Status collapse
  // --------------------------------------------------------------------------
  always_comb begin : collapse_status
    status_o = '0;
    for (int unsigned i = 0; i < NumLanes; i++) begin
      if (i < used_lanes && mask_i[i]) begin
        status_o |= lanes_i[i].status; // Masked-off lanes report nothing
      end
    end
  end

endmodule

/* logic/fp_nc_slice.sv */
`timescale 1ns/10ps

module fp_nc_slice import fpslice_pkg::*; #(
  parameter int unsigned Width       = 64,
  parameter int unsigned NumPipeRegs = 1,
  localparam int unsigned NumLanes = Width / MIN_LANE_WIDTH
) (
  input  logic                 clk_i,
  input  logic                 rst_i,
  // Operation
  input  logic [1:0][Width-1:0] operands_i,
  input  nc_op_e               op_i,
  input  fp_fmt_e              fmt_i,
  input  logic                 vectorial_op_i,
  input  tag_t                 tag_i,
  input  logic [NumLanes-1:0]  simd_mask_i,
  // Input handshake
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  logic                 flush_i,
  // Result
  output logic [Width-1:0]     result_o,
  output status_t              status_o,
  output tag_t                 tag_o,
  // Output handshake
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic                 busy_o
);

  localparam int unsigned NumLanes32 = num_lanes(Width, FMT_FP32);

  lane_ctrl_t               lane_ctrl;
  lane_word_t [NumLanes-1:0] lane_a, lane_b;
  slice_aux_t               dec_aux, pipe_aux;
  lane_res_t [NumLanes-1:0] lane_res, pipe_lanes;
  logic [NumLanes-1:0]      pipe_mask;

  // --------------------------------------------------------------------------
  // Input side
  // --------------------------------------------------------------------------
  slice_decode #(
    .Width ( Width )
  ) i_decode (
    .operands_i,
    .op_i,
    .fmt_i,
    .vectorial_op_i,
    .tag_i,
    .ctrl_o   ( lane_ctrl ),
    .lane_a_o ( lane_a    ),
    .lane_b_o ( lane_b    ),
    .aux_o    ( dec_aux   )
  );

  // --------------------------------------------------------------------------
  // Lanes
  // --------------------------------------------------------------------------
  for (genvar l = 0; l < NumLanes; l++) begin : gen_lanes
    lane_nc_unit #(
      .SupportsFp32 ( l < NumLanes32 ) // Upper lanes only ever carry FP16
    ) i_lane (
      .ctrl_i ( lane_ctrl   ),
      .a_i    ( lane_a[l]   ),
      .b_i    ( lane_b[l]   ),
      .res_o  ( lane_res[l] )
    );
  end

  // All lanes move in lockstep through one pipeline
  slice_pipe #(
    .Width       ( Width       ),
    .NumPipeRegs ( NumPipeRegs )
  ) i_pipe (
    .clk_i,
    .rst_i,
    .flush_i,
    .in_valid_i,
    .in_ready_o,
    .lanes_i     ( lane_res    ),
    .aux_i       ( dec_aux     ),
    .mask_i      ( simd_mask_i ),
    .out_valid_o,
    .out_ready_i,
    .lanes_o     ( pipe_lanes  ),
    .aux_o       ( pipe_aux    ),
    .mask_o      ( pipe_mask   ),
    .busy_o
  );

  // --------------------------------------------------------------------------
  // Output side
  // --------------------------------------------------------------------------
  slice_result #(
    .Width ( Width )
  ) i_result (
    .lanes_i ( pipe_lanes ),
    .aux_i   ( pipe_aux   ),
    .mask_i  ( pipe_mask  ),
    .result_o,
    .status_o,
    .tag_o
  );

endmodule

/* bench/slice_model.svh */
`ifndef SLICE_MODEL_SVH
`define SLICE_MODEL_SVH

// Expected output of one accepted operation
typedef struct packed {
  logic [Width-1:0] result;
  status_t          status;
  tag_t             tag;
} expect_t;

// Total order key, -0 sorts below +0
function automatic logic [31:0] order_key(logic [31:0] x);
  return x[31] ? ~x : (x | 32'h8000_0000);
endfunction

// One lane, elements left aligned so FP16 shares the FP32 sign position
function automatic logic [31:0] model_lane(nc_op_e op, fp_fmt_e fmt, logic [31:0] a_raw,
                                           logic [31:0] b_raw, output logic nv);
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] res;
  logic [31:0] canon;
  logic        a_nan;
  logic        b_nan;
  logic        a_snan;
  logic        b_snan;
  logic        sign;
  int unsigned shift;
  shift = (fmt == FMT_FP32) ? 0 : 16;
  a = a_raw << shift;
  b = b_raw << shift;
  if (fmt == FMT_FP32) begin
    a_nan  = (a[30:23] == 8'hff) && (a[22:0] != 0);
    b_nan  = (b[30:23] == 8'hff) && (b[22:0] != 0);
    a_snan = a_nan && !a[22];
    b_snan = b_nan && !b[22];
    canon  = 32'h7fc0_0000;
  end else begin
    a_nan  = (a[30:26] == 5'h1f) && (a[25:16] != 0);
    b_nan  = (b[30:26] == 5'h1f) && (b[25:16] != 0);
    a_snan = a_nan && !a[25];
    b_snan = b_nan && !b[25];
    canon  = 32'h7e00_0000;
  end
  nv = 1'b0;
  if (op == OP_MIN || op == OP_MAX) begin
    nv = a_snan | b_snan;
    if (a_nan && b_nan) res = canon;
    else if (a_nan) res = b;            // The number wins over a NaN
    else if (b_nan) res = a;
    else if ((order_key(a) < order_key(b)) == (op == OP_MIN)) res = a;
    else res = b;
  end else begin
    if (op == OP_SGNJ) sign = b[31];
    else if (op == OP_SGNJN) sign = ~b[31];
    else sign = a[31] ^ b[31];
    res = {sign, a[30:0]};
  end
  return res >> shift;                  // FP16 comes back in the low half
endfunction

function automatic expect_t model_item(nc_op_e op, fp_fmt_e fmt, logic vec, tag_t tag,
                                       logic [NumLanes-1:0] mask,
                                       logic [1:0][Width-1:0] opnds);
  expect_t     e;
  logic [31:0] v;
  logic        nv;
  int unsigned ew;
  int unsigned n;
  ew = (fmt == FMT_FP32) ? 32 : 16;
  n  = vec ? Width / ew : 1;
  e.result = '1;                        // NaN-box above the used elements
  e.status = '0;
  e.tag    = tag;
  for (int unsigned i = 0; i < n; i++) begin
    v = model_lane(op, fmt, 32'(opnds[0] >> (i * ew)), 32'(opnds[1] >> (i * ew)), nv);
    if (ew == 32) e.result[i*32 +: 32] = v;
    else e.result[i*16 +: 16] = v[15:0];
    e.status.nv |= nv & mask[i];
  end
  return e;
endfunction

`endif

/* bench/slice_tb.sv */
`timescale 1ns/10ps

module slice_tb import fpslice_pkg::*; ();

  localparam int unsigned Width       = 64;
  localparam int unsigned NumPipeRegs = 2;
  localparam int unsigned NumLanes    = Width / 16;
  localparam int unsigned NumRandom   = 400;
  localparam int unsigned Timeout     = 100; // Cycles per wait

  typedef enum {READY_ON, READY_RANDOM, READY_OFF} ready_mode_e;

  logic                  clk_i;
  logic                  rst_i;
  logic [1:0][Width-1:0] operands_i;
  nc_op_e                op_i;
  fp_fmt_e               fmt_i;
  logic                  vectorial_op_i;
  tag_t                  tag_i;
  logic [NumLanes-1:0]   simd_mask_i;
  logic                  in_valid_i;
  logic                  in_ready_o;
  logic                  flush_i;
  logic [Width-1:0]      result_o;
  status_t               status_o;
  tag_t                  tag_o;
  logic                  out_valid_o;
  logic                  out_ready_i;
  logic                  busy_o;

  integer      seed = 66197;
  ready_mode_e ready_mode;
  int unsigned num_accepted;

  `include "slice_model.svh"

  expect_t expect_q[$];

  fp_nc_slice #(.Width(Width), .NumPipeRegs(NumPipeRegs)) uut (.*);

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic stop_on_error(string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  // --------------------------------------------------------------------------
  // Scoreboard, sampled 1 ns before the rising edge
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin : monitor
    expect_t want;
    #3;
    if (!rst_i) begin
      if (in_valid_i && in_ready_o) begin
        expect_q.push_back(model_item(op_i, fmt_i, vectorial_op_i, tag_i, simd_mask_i,
                                      operands_i));
        num_accepted++;
      end
      if (out_valid_o && out_ready_i) begin
        assert (expect_q.size() != 0) else
          stop_on_error("Output handshake while no item was outstanding");
        want = expect_q.pop_front();
        assert (result_o === want.result) else
          stop_on_error($sformatf("** Error: result_o = %h, expected %h", result_o, want.result));
        assert (status_o === want.status) else
          stop_on_error($sformatf("** Error: status_o = %h, expected %h", status_o, want.status));
        assert (tag_o === want.tag) else
          stop_on_error($sformatf("** Error: tag_o = %h, expected %h", tag_o, want.tag));
      end
      if (flush_i) expect_q.delete();   // Flushed items must never show up
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------
  task automatic next_cycle();
    @(negedge clk_i);
    case (ready_mode)
      READY_RANDOM: out_ready_i = ($random(seed) % 4) != 0;
      READY_OFF:    out_ready_i = 1'b0;
      default:      out_ready_i = 1'b1;
    endcase
  endtask

  task automatic send_item(nc_op_e op, fp_fmt_e fmt, logic vec, logic [NumLanes-1:0] mask,
                           logic [Width-1:0] a, logic [Width-1:0] b);
    int unsigned start;
    int unsigned waited;
    start          = num_accepted;
    waited         = 0;
    operands_i     = {b, a};
    op_i           = op;
    fmt_i          = fmt;
    vectorial_op_i = vec;
    simd_mask_i    = mask;
    tag_i          = tag_t'($random(seed));
    in_valid_i     = 1'b1;
    do begin
      next_cycle();
      waited++;
      if (waited > Timeout) stop_on_error("Timed out waiting for the slice to take an item");
    end while (num_accepted == start);
    in_valid_i = 1'b0;
  endtask

  task automatic wait_drained();
    int unsigned waited;
    waited = 0;
    while (expect_q.size() != 0 || busy_o) begin
      next_cycle();
      waited++;
      if (waited > Timeout) stop_on_error("Timed out waiting for the pipeline to drain");
    end
  endtask

  // Zeros and NaNs of both kinds show up far more often than by chance
  function automatic logic [31:0] special_elem(fp_fmt_e fmt);
    logic [31:0] r;
    logic        wide;
    r    = $random(seed);
    wide = (fmt == FMT_FP32);
    case ($unsigned($random(seed)) % 6)
      0: return wide ? {r[31], 31'h0} : {16'h0, r[15], 15'h0};
      1: return wide ? {r[31], 9'h1ff, r[21:0]} : {16'h0, r[15], 6'h3f, r[8:0]};
      2: return wide ? {r[31], 8'hff, 1'b0, r[21:1], 1'b1}
                     : {16'h0, r[15], 5'h1f, 1'b0, r[8:1], 1'b1};
      default: return r;
    endcase
  endfunction

  function automatic logic [Width-1:0] random_word(fp_fmt_e fmt);
    logic [Width-1:0] w;
    logic [31:0]      e;
    w = '0;
    for (int i = 0; i < NumLanes; i++) begin
      e = special_elem(fmt);
      if (fmt == FMT_FP16) w[i*16 +: 16] = e[15:0];
      else if (i % 2 == 0) w[i*16 +: 32] = e;
    end
    return w;
  endfunction

  task automatic send_random();
    logic [31:0]      r;
    fp_fmt_e          fmt;
    logic [Width-1:0] a;
    logic [Width-1:0] b;
    r   = $random(seed);
    fmt = r[0] ? FMT_FP16 : FMT_FP32;
    a   = random_word(fmt);
    b   = random_word(fmt);
    send_item(nc_op_e'(3'(r[15:8] % 5)), fmt, r[1], r[4 +: NumLanes], a, b);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin : stimulus
    rst_i          = 1'b1;
    flush_i        = 1'b0;
    in_valid_i     = 1'b0;
    out_ready_i    = 1'b1;
    operands_i     = '0;
    op_i           = OP_MIN;
    fmt_i          = FMT_FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '1;
    ready_mode     = READY_ON;
    num_accepted   = 0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    assert (out_valid_o === 1'b0) else
      stop_on_error($sformatf("** Error: out_valid_o = %h, expected 0", out_valid_o));
    assert (busy_o === 1'b0) else
      stop_on_error($sformatf("** Error: busy_o = %h, expected 0", busy_o));
    assert (in_ready_o === 1'b1) else
      stop_on_error($sformatf("** Error: in_ready_o = %h, expected 1", in_ready_o));

    // Scalar min/max around signed zeros and NaNs
    send_item(OP_MIN, FMT_FP32, 1'b0, '1, 64'h8000_0000, 64'h0);
    send_item(OP_MAX, FMT_FP32, 1'b0, '1, 64'h8000_0000, 64'h0);
    send_item(OP_MIN, FMT_FP32, 1'b0, '1, 64'h7fc0_0001, 64'h3f80_0000);
    send_item(OP_MAX, FMT_FP32, 1'b0, '1, 64'h7f80_0001, 64'h4000_0000);
    send_item(OP_MIN, FMT_FP16, 1'b0, '1, 64'h7c01, 64'h7e00);
    send_item(OP_MAX, FMT_FP16, 1'b0, '1, 64'h8000, 64'h0000);
    send_item(OP_MIN, FMT_FP16, 1'b0, '1, 64'h7d00_3c00, 64'h0);  // sNaN outside lane 0
    // Vector sign injection
    send_item(OP_SGNJ, FMT_FP16, 1'b1, '1, 64'h3c00_bc00_4000_c000, 64'h8000_0000_8000_0000);
    send_item(OP_SGNJN, FMT_FP32, 1'b1, '1, 64'h3f80_0000_c000_0000, 64'h8000_0000_0000_0000);
    send_item(OP_SGNJX, FMT_FP16, 1'b1, '1, 64'hbc00_3c00_bc00_3c00, 64'h8000_8000_0000_0000);
    // Invalid flag only from unmasked lanes
    send_item(OP_MIN, FMT_FP16, 1'b1, 4'b1101, 64'h3c00_3c00_7d00_3c00, 64'h0);
    send_item(OP_MIN, FMT_FP16, 1'b1, 4'b1111, 64'h3c00_3c00_7d00_3c00, 64'h0);
    wait_drained();

    ready_mode = READY_RANDOM;
    repeat (NumRandom) send_random();
    ready_mode = READY_ON;
    wait_drained();

    // Fill both stages behind a stalled output, then flush
    ready_mode = READY_OFF;
    next_cycle();
    send_random();
    send_random();
    flush_i = 1'b1;
    next_cycle();
    flush_i    = 1'b0;
    ready_mode = READY_ON;
    wait_drained();
    send_random();
    wait_drained();

    $display("Regression passed");
    $finish;
  end

endmodule

/* compile.f */
+incdir+bench
logic/fpslice_pkg.sv
logic/slice_decode.sv
logic/lane_nc_unit.sv
logic/slice_pipe.sv
logic/slice_result.sv
logic/fp_nc_slice.sv
bench/slice_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the slice testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module slice_tb -Mdir "$BUILD_DIR" -o slice_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/slice_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Regression failed" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
if ! grep -q "Regression passed" "$LOG"; then
  echo "Simulation ended without a result"
  exit 1
fi
exit 0
